/* sim.f */
common/execPkg.sv
alu/aluCore.sv
mul/mulMerge.sv
hilo/hiloUnit.sv
src/execCtrl.sv
src/execTop.sv
bench/execTop_chk.sv
bench/execTb.sv

/* Makefile */
SIM  := obj_dir/VexecTb
SRCS := $(filter-out +%,$(shell cat sim.f))

.PHONY: all run clean

all: run

$(SIM): sim.f $(SRCS)
	verilator --binary --assert --top-module execTb -f sim.f

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir

/* bench/execTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage testbench
// Directed and random requests with a HI/LO reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module execTb;

    logic            clk;
    logic            rst;
    logic            reqValid;
    execPkg::execReq req;
    logic            busy;
    logic            resValid;
    execPkg::word    resData;
    execPkg::dword   model;
    int unsigned     tbErrors;
    int unsigned     seedOut;

    execTop DUT (
        .clk     (clk),
        .rst     (rst),
        .reqValid(reqValid),
        .req     (req),
        .busy    (busy),
        .resValid(resValid),
        .resData (resData)
    );

    bind execTop execTop_chk uChk (
        .clk     (clk),
        .rst     (rst),
        .reqValid(reqValid),
        .req     (req),
        .busy    (busy),
        .resValid(resValid),
        .resData (resData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Full 64-bit product, operands widened by sign or by zeros
    function automatic execPkg::dword fullProduct(input logic signedMul,
                                                  input execPkg::word a,
                                                  input execPkg::word b);
        execPkg::dword wideA;
        execPkg::dword wideB;

        wideA = signedMul ? {{32{a[31]}}, a} : {32'b0, a};
        wideB = signedMul ? {{32{b[31]}}, b} : {32'b0, b};
        return wideA * wideB;
    endfunction

    task automatic sendReq(input execPkg::aluOp op, input execPkg::word a,
                           input execPkg::word b);
        reqValid <= 1'b1;
        req      <= {op, a, b};
        @(posedge clk);
        reqValid <= 1'b0;
    endtask

    task automatic waitResult(output execPkg::word data);
        bit got;

        got  = 1'b0;
        data = '0;
        for (int i = 0; i < 8 && !got; i++) begin
            @(posedge clk);
            if (resValid) begin
                data = resData;
                got  = 1'b1;
            end
        end
        if (!got) begin
            $display("ERROR: no result strobe within 8 cycles");
            tbErrors++;
        end
    endtask

    task automatic waitIdle();
        bit idle;

        idle = 1'b0;
        for (int i = 0; i < 8 && !idle; i++) begin
            @(posedge clk);
            idle = !busy;
        end
        if (!idle) begin
            $display("ERROR: busy still high after 8 cycles");
            tbErrors++;
        end
    endtask

    task automatic checkValue(input string name, input execPkg::word expected,
                              input execPkg::word actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            tbErrors++;
        end
    endtask

    task automatic readHilo(input string name);
        execPkg::word value;

        sendReq(execPkg::opMfhi, 32'd0, 32'd0);
        waitResult(value);
        checkValue({name, " HI"}, model[63:32], value);
        sendReq(execPkg::opMflo, 32'd0, 32'd0);
        waitResult(value);
        checkValue({name, " LO"}, model[31:0], value);
    endtask

    task automatic mulCheck(input execPkg::word a, input execPkg::word b);
        execPkg::dword product;
        execPkg::word  value;

        product = fullProduct(1'b1, a, b);
        sendReq(execPkg::opMul, a, b);
        waitResult(value);
        checkValue("MUL", product[31:0], value);
    endtask

    // Model first, then the DUT, then read both halves back
    task automatic accumulate(input execPkg::aluOp op, input execPkg::word a,
                              input execPkg::word b);
        execPkg::dword product;

        product = fullProduct(op inside {execPkg::opMult, execPkg::opMadd, execPkg::opMsub},
                              a, b);
        case (op)
            execPkg::opMult,
            execPkg::opMultu: model = product;
            execPkg::opMadd,
            execPkg::opMaddu: model = model + product;
            default:          model = model - product;
        endcase
        sendReq(op, a, b);
        waitIdle();
        readHilo(op.name());
    endtask

    initial begin
        execPkg::aluOp accOps [6];
        execPkg::aluOp op;
        logic [4:0]    pick;
        int unsigned   chkErrors;

        accOps   = '{execPkg::opMult, execPkg::opMultu, execPkg::opMadd,
                     execPkg::opMaddu, execPkg::opMsub, execPkg::opMsubu};
        seedOut  = $urandom(32'h230c);
        tbErrors = 0;
        model    = '0;
        rst      <= 1'b1;
        reqValid <= 1'b0;
        req      <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        readHilo("RESET");

        // Simple operations occupy the first 16 codes
        for (int i = 0; i < 400; i++) begin
            pick = 5'($urandom_range(15, 0));
            op   = execPkg::aluOp'(pick);
            sendReq(op, $urandom(), $urandom());
        end

        sendReq(execPkg::opClz, 32'd0, 32'd0);
        sendReq(execPkg::opClo, 32'hffff_ffff, 32'd0);
        sendReq(execPkg::opClz, 32'hffff_ffff, 32'd0);
        sendReq(execPkg::opClo, 32'd0, 32'd0);
        for (int i = 0; i < 32; i++) begin
            sendReq(execPkg::opClz, 32'd1 << i, 32'd0);
            sendReq(execPkg::opClo, ~(32'd1 << i), 32'd0);
        end
        @(posedge clk);

        mulCheck(32'hffff_fffd, 32'd7);
        mulCheck(32'h7fff_ffff, 32'd2);
        mulCheck(32'h8000_0000, 32'hffff_ffff);
        for (int i = 0; i < 20; i++) begin
            mulCheck($urandom(), $urandom());
        end

        sendReq(execPkg::opMthi, 32'h1234_5678, 32'd0);
        sendReq(execPkg::opMtlo, 32'h9abc_def0, 32'd0);
        model = 64'h1234_5678_9abc_def0;
        readHilo("MOVE");

        // Negative operand first so signed and unsigned differ
        accumulate(execPkg::opMult, 32'hffff_fff0, 32'd3);
        accumulate(execPkg::opMultu, 32'hffff_fff0, 32'd3);
        for (int i = 0; i < 24; i++) begin
            accumulate(accOps[i % 6], $urandom(), $urandom());
        end

        repeat (4) @(posedge clk);
        chkErrors = DUT.uChk.failCount;
        $display("Errors: testbench %0d, assertions %0d", tbErrors, chkErrors);
        if (tbErrors + chkErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/execTop_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage assertions
// Result timing, simple-operation values and busy behavior, bound
// onto the execute stage top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module execTop_chk (
    input logic            clk,
    input logic            rst,
    input logic            reqValid,
    input execPkg::execReq req,
    input logic            busy,
    input logic            resValid,
    input execPkg::word    resData
);

    int unsigned  failCount;
    logic         accepted;
    logic         mulKind;
    logic         moveAcc;
    logic         hiloRead;
    logic         simpleAcc;
    logic         mulAcc;
    logic         multAcc;
    execPkg::word expNow;
    execPkg::word expPrev;

    // Results as the instruction set defines them
    function automatic execPkg::word expectedResult(input execPkg::aluOp op,
                                                    input execPkg::word a,
                                                    input execPkg::word b);
        execPkg::word result;
        logic         lead;
        logic         counting;

        result   = 32'd0;
        lead     = (op == execPkg::opClo);
        counting = 1'b1;
        case (op)
            execPkg::opSll:  result = b << a[4:0];
            execPkg::opSrl:  result = b >> a[4:0];
            execPkg::opSra:  result = $signed(b) >>> a[4:0];
            execPkg::opAdd,
            execPkg::opAddu: result = a + b;
            execPkg::opSub,
            execPkg::opSubu: result = a - b;
            execPkg::opAnd:  result = a & b;
            execPkg::opOr:   result = a | b;
            execPkg::opXor:  result = a ^ b;
            execPkg::opNor:  result = ~(a | b);
            execPkg::opSlt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            execPkg::opSltu: result = (a < b) ? 32'd1 : 32'd0;
            execPkg::opMov:  result = a;
            execPkg::opClo,
            execPkg::opClz: begin
                // Walk down from the MSB until the run breaks
                for (int i = 31; i >= 0; i--) begin
                    if (counting && a[i] == lead) begin
                        result = result + 32'd1;
                    end else begin
                        counting = 1'b0;
                    end
                end
            end
            default:         result = 32'd0;
        endcase
        return result;
    endfunction

    initial failCount = 0;

    assign accepted  = reqValid && !busy;
    assign mulKind   = req.op inside {execPkg::opMul, execPkg::opMult, execPkg::opMultu,
                                      execPkg::opMadd, execPkg::opMaddu,
                                      execPkg::opMsub, execPkg::opMsubu};
    assign moveAcc   = accepted && (req.op == execPkg::opMthi || req.op == execPkg::opMtlo);
    assign hiloRead  = (req.op == execPkg::opMfhi) || (req.op == execPkg::opMflo);
    assign simpleAcc = accepted && !mulKind && !moveAcc;
    assign mulAcc    = accepted && req.op == execPkg::opMul;
    assign multAcc   = accepted && mulKind && req.op != execPkg::opMul;
    assign expNow    = expectedResult(req.op, req.opr1, req.opr2);

    always_ff @(posedge clk) begin
        expPrev <= expNow;
    end

    simpleStrobe: assert property (@(posedge clk) disable iff (rst) simpleAcc |=> resValid)
        else begin
            failCount++;
            $error("simple operation gave no result strobe one cycle later");
        end

    // HI/LO reads are compared against the testbench model instead
    simpleData: assert property (@(posedge clk) disable iff (rst)
        simpleAcc && !hiloRead |=> resData == expPrev)
        else begin
            failCount++;
            $error("FAIL simpleData: expected %h, actual %h",
                   $sampled(expPrev), $sampled(resData));
        end

    mulStrobe: assert property (@(posedge clk) disable iff (rst) $past(mulAcc, 2) |-> resValid)
        else begin
            failCount++;
            $error("MUL result strobe did not come two cycles after the request");
        end

    silentOps: assert property (@(posedge clk) disable iff (rst)
        $past(multAcc, 2) || $past(moveAcc) |-> !resValid)
        else begin
            failCount++;
            $error("HI/LO-only operation produced a result strobe");
        end

    busyRise: assert property (@(posedge clk) disable iff (rst) accepted && mulKind |=> busy)
        else begin
            failCount++;
            $error("busy did not rise after a multiply");
        end

    busyPulse: assert property (@(posedge clk) disable iff (rst) busy |=> !busy)
        else begin
            failCount++;
            $error("busy stayed high for more than one cycle");
        end

    noReqWhenBusy: assert property (@(posedge clk) disable iff (rst) busy |-> !reqValid)
        else begin
            failCount++;
            $error("request strobed while busy was high");
        end

    resetState: assert property (@(posedge clk) $fell(rst) |-> !resValid && !busy)
        else begin
            failCount++;
            $error("result strobe or busy high right after reset");
        end

endmodule

/* src/execTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage top level
// Control, ALU, multiply merge and HI/LO unit with the result register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module execTop (
    input  logic            clk,
    input  logic            rst,
    input  logic            reqValid,
    input  execPkg::execReq req,
    output logic            busy,
    output logic            resValid,
    output execPkg::word    resData
);

    execPkg::word      aluRes;
    execPkg::mulParts  parts;
    execPkg::dword     product;
    execPkg::dword     hilo;
    execPkg::hiloMode  hiloMode;
    execPkg::hiloWrite hiloCmd;
    logic              latchRes;
    logic              mulStart;
    logic              mulDone;

    execCtrl uCtrl (
        .clk     (clk),
        .rst     (rst),
        .reqValid(reqValid),
        .op      (req.op),
        .latchRes(latchRes),
        .mulStart(mulStart),
        .mulDone (mulDone),
        .hiloCmd (hiloMode),
        .resValid(resValid),
        .busy    (busy)
    );

    aluCore uAlu (
        .req   (req),
        .hilo  (hilo),
        .aluRes(aluRes),
        .parts (parts)
    );

    mulMerge uMerge (
        .clk     (clk),
        .rst     (rst),
        .mulStart(mulStart),
        .parts   (parts),
        .product (product)
    );

    // Set modes write opr1, the rest take the merged product
    always_comb begin
        hiloCmd.mode = hiloMode;
        if (hiloMode == execPkg::hiloSetHi || hiloMode == execPkg::hiloSetLo) begin
            hiloCmd.value = {32'b0, req.opr1};
        end else begin
            hiloCmd.value = product;
        end
    end

    hiloUnit uHilo (
        .clk (clk),
        .rst (rst),
        .cmd (hiloCmd),
        .hilo(hilo)
    );

    always_ff @(posedge clk) begin
        if (latchRes) begin
            resData <= aluRes;
        end else if (mulDone) begin
            resData <= product[31:0];
        end
    end

endmodule

/* src/execCtrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage control
// Classifies each request, tracks the multiply in flight and drives
// busy, the result strobe and the HI/LO command
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module execCtrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             reqValid,
    input  execPkg::aluOp    op,
    output logic             latchRes,
    output logic             mulStart,
    output logic             mulDone,
    output execPkg::hiloMode hiloCmd,
    output logic             resValid,
    output logic             busy
);

    logic             accept;
    logic             isMul;
    logic             isSimple;
    execPkg::hiloMode mulMode;
    logic             pending;
    logic             pendRes;
    execPkg::hiloMode pendMode;

    // Requests during a pending multiply are dropped
    assign accept = reqValid && !pending;

    always_comb begin
        isMul   = 1'b1;
        mulMode = execPkg::hiloNone;
        case (op)
            execPkg::opMul:   mulMode = execPkg::hiloNone;
            execPkg::opMult,
            execPkg::opMultu: mulMode = execPkg::hiloLoad;
            execPkg::opMadd,
            execPkg::opMaddu: mulMode = execPkg::hiloAdd;
            execPkg::opMsub,
            execPkg::opMsubu: mulMode = execPkg::hiloSub;
            default:          isMul = 1'b0;
        endcase
    end

    assign isSimple = !isMul && (op != execPkg::opMthi) && (op != execPkg::opMtlo);

    assign latchRes = accept && isSimple;
    assign mulStart = accept && isMul;
    assign mulDone  = pending;
    assign busy     = pending;

    // Multiply completion owns HI/LO, otherwise a direct move
    always_comb begin
        if (pending) begin
            hiloCmd = pendMode;
        end else if (accept && op == execPkg::opMthi) begin
            hiloCmd = execPkg::hiloSetHi;
        end else if (accept && op == execPkg::opMtlo) begin
            hiloCmd = execPkg::hiloSetLo;
        end else begin
            hiloCmd = execPkg::hiloNone;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= 1'b0;
            pendRes  <= 1'b0;
            pendMode <= execPkg::hiloNone;
            resValid <= 1'b0;
        end else begin
            pending  <= mulStart;
            if (mulStart) begin
                pendRes  <= (op == execPkg::opMul);
                pendMode <= mulMode;
            end
            resValid <= latchRes || (pending && pendRes);
        end
    end

endmodule

/* hilo/hiloUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HI/LO register pair
// Loads, accumulates or subtracts a product, or sets one half directly
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hiloUnit (
    input  logic              clk,
    input  logic              rst,
    input  execPkg::hiloWrite cmd,
    output execPkg::dword     hilo
);

    execPkg::word hi;
    execPkg::word lo;
    execPkg::dword acc;
    execPkg::dword next;

    assign acc = {hi, lo};

    always_comb begin
        case (cmd.mode)
            execPkg::hiloLoad:  next = cmd.value;
            execPkg::hiloAdd:   next = acc + cmd.value;
            execPkg::hiloSub:   next = acc - cmd.value;
            // Set modes carry the register value in the low word
            execPkg::hiloSetHi: next = {cmd.value[31:0], lo};
            execPkg::hiloSetLo: next = {hi, cmd.value[31:0]};
            default:            next = acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= 32'b0;
            lo <= 32'b0;
        end else begin
            hi <= next[63:32];
            lo <= next[31:0];
        end
    end

    assign hilo = acc;

endmodule

/* mul/mulMerge.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply second stage
// Holds the partial products and sums them into a signed 64-bit product
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mulMerge (
    input  logic             clk,
    input  logic             rst,
    input  logic             mulStart,
    input  execPkg::mulParts parts,
    output execPkg::dword    product
);

    execPkg::mulParts held;
    execPkg::dword    magnitude;

    // Captured on the request cycle, read the following cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (mulStart) begin
            held <= parts;
        end
    end

    // Cross terms land 16 bits up, the high product 32 bits up
    always_comb begin
        execPkg::dword sumLow;
        execPkg::dword sumMid;
        execPkg::dword sumHigh;

        sumLow    = {32'b0, held.ll};
        sumMid    = {16'b0, held.hl, 16'b0} + {16'b0, held.lh, 16'b0};
        sumHigh   = {held.hh, 32'b0};
        magnitude = sumLow + sumMid + sumHigh;
    end

    assign product = held.neg ? ~magnitude + 64'd1 : magnitude;

endmodule

/* alu/aluCore.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU
// Shifts, add/sub, logic, compares, CLO/CLZ, HI/LO reads and the
// first multiply stage that forms four 16x16 partial products
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module aluCore (
    input  execPkg::execReq  req,
    input  execPkg::dword    hilo,
    output execPkg::word     aluRes,
    output execPkg::mulParts parts
);

    execPkg::word opr1;
    execPkg::word opr2;
    execPkg::word clzOpr;
    execPkg::word clzRes;
    execPkg::word mopr1;
    execPkg::word mopr2;
    logic         mulNeg;

    assign opr1 = req.opr1;
    assign opr2 = req.opr2;

    // Leading-bit count, halving the search window each step
    always_comb begin
        logic        n4;
        logic        n3;
        logic        n2;
        logic [1:0]  low;
        logic [15:0] part1;
        logic [7:0]  part2;
        logic [3:0]  part3;

        clzOpr = (req.op == execPkg::opClo) ? ~opr1 : opr1;
        n4     = (clzOpr[31:16] == 16'b0);
        part1  = n4 ? clzOpr[15:0] : clzOpr[31:16];
        n3     = (part1[15:8] == 8'b0);
        part2  = n3 ? part1[7:0] : part1[15:8];
        n2     = (part2[7:4] == 4'b0);
        part3  = n2 ? part2[3:0] : part2[7:4];
        casez (part3)
            4'b0001: low = 2'd3;
            4'b001?: low = 2'd2;
            4'b01??: low = 2'd1;
            default: low = 2'd0;
        endcase

        if (clzOpr == 32'b0) begin
            clzRes = 32'd32;
        end else begin
            clzRes = {27'b0, n4, n3, n2, low};
        end
    end

    // Multiply operands as magnitudes, sign carried separately
    always_comb begin
        case (req.op)
            execPkg::opMul,
            execPkg::opMult,
            execPkg::opMadd,
            execPkg::opMsub: begin
                mopr1  = opr1[31] ? ~opr1 + 32'd1 : opr1;
                mopr2  = opr2[31] ? ~opr2 + 32'd1 : opr2;
                mulNeg = opr1[31] ^ opr2[31];
            end
            execPkg::opMultu,
            execPkg::opMaddu,
            execPkg::opMsubu: begin
                mopr1  = opr1;
                mopr2  = opr2;
                mulNeg = 1'b0;
            end
            default: begin
                mopr1  = 32'b0;
                mopr2  = 32'b0;
                mulNeg = 1'b0;
            end
        endcase
    end

    assign parts.ll  = {16'b0, mopr1[15:0]} * {16'b0, mopr2[15:0]};
    assign parts.hl  = {16'b0, mopr1[31:16]} * {16'b0, mopr2[15:0]};
    assign parts.lh  = {16'b0, mopr1[15:0]} * {16'b0, mopr2[31:16]};
    assign parts.hh  = {16'b0, mopr1[31:16]} * {16'b0, mopr2[31:16]};
    assign parts.neg = mulNeg;

    always_comb begin
        case (req.op)
            execPkg::opSll:  aluRes = opr2 << opr1[4:0];
            execPkg::opSrl:  aluRes = opr2 >> opr1[4:0];
            execPkg::opSra:  aluRes = $signed(opr2) >>> opr1[4:0];
            execPkg::opAdd,
            execPkg::opAddu: aluRes = opr1 + opr2;
            execPkg::opSub,
            execPkg::opSubu: aluRes = opr1 - opr2;
            execPkg::opAnd:  aluRes = opr1 & opr2;
            execPkg::opOr:   aluRes = opr1 | opr2;
            execPkg::opXor:  aluRes = opr1 ^ opr2;
            execPkg::opNor:  aluRes = ~(opr1 | opr2);
            execPkg::opSlt:  aluRes = {31'b0, $signed(opr1) < $signed(opr2)};
            execPkg::opSltu: aluRes = {31'b0, opr1 < opr2};
            execPkg::opMov,
            execPkg::opMthi,
            execPkg::opMtlo: aluRes = opr1;
            execPkg::opMfhi: aluRes = hilo[63:32];
            execPkg::opMflo: aluRes = hilo[31:0];
            execPkg::opClo,
            execPkg::opClz:  aluRes = clzRes;
            default:         aluRes = 32'b0;
        endcase
    end

endmodule

/* common/execPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage shared definitions
// Operation codes, data words and the bundles passed between the
// ALU, the multiply merge stage and the HI/LO registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package execPkg;

    typedef logic [31:0] word;

    // HI sits in the upper half
    typedef logic [63:0] dword;

    typedef enum logic [4:0] {
        opSll,
        opSrl,
        opSra,
        opAdd,
        opAddu,
        opSub,
        opSubu,
        opAnd,
        opOr,
        opXor,
        opNor,
        opSlt,
        opSltu,
        opMov,
        opClo,
        opClz,
        opMul,
        opMult,
        opMultu,
        opMadd,
        opMaddu,
        opMsub,
        opMsubu,
        opMthi,
        opMtlo,
        opMfhi,
        opMflo
    } aluOp;

    typedef struct packed {
        aluOp op;
        word  opr1;
        word  opr2;
    } execReq;

    // Four 16x16 partial products plus the sign of the final product
    typedef struct packed {
        word  ll;
        word  hl;
        word  lh;
        word  hh;
        logic neg;
    } mulParts;

    typedef enum logic [2:0] {
        hiloNone,
        hiloLoad,
        hiloAdd,
        hiloSub,
        hiloSetHi,
        hiloSetLo
    } hiloMode;

    typedef struct packed {
        hiloMode mode;
        dword    value;
    } hiloWrite;

endpackage
